/* hdl/rs_params.svh */
// sizes and constants for the RS(204,188) error detector
// include this file wherever a module needs block sizes or the field polynomial
// the include guard keeps repeated includes harmless
`ifndef RS_PARAMS_SVH
`define RS_PARAMS_SVH

// code shape
`define RS_N            204     // bytes per received block
`define RS_K            188     // data bytes per block
`define RS_PARITY       16      // parity bytes, also number of syndromes

// GF(256) field
`define RS_GF_POLY      9'h11d  // x^8 + x^4 + x^3 + x^2 + 1

// output pacing and memory addressing
`define RS_OUT_SPACING  8       // clocks between output bytes
`define RS_ADDR_W       8       // block position / bank address width

`endif

/* hdl/rs_pkg.sv */
// shared types and GF(256) arithmetic for the RS(204,188) detector
// every RTL module except the memory imports this package by wildcard
`default_nettype none

`include "rs_params.svh"

package rs_pkg;

	localparam logic [8:0] GF_POLY = `RS_GF_POLY;   // full field polynomial

	typedef logic [7:0] rs_byte_t;                  // one GF(256) symbol
	typedef logic [`RS_ADDR_W-1:0] rs_addr_t;       // block position or bank address

	// registered input byte with its place in the block
	typedef struct packed {
		logic     ce;      // byte valid this clock
		rs_byte_t data;
		rs_addr_t index;   // 0 .. RS_N-1
	} in_beat_t;

	// end of block report
	typedef struct packed {
		logic ready;       // one clock pulse
		logic error;       // some syndrome nonzero
	} blk_status_t;

	// read request into a bank
	typedef struct packed {
		logic     en;
		rs_addr_t addr;
	} rd_req_t;

	// shift and add multiply, reducing by the field polynomial each step
	function automatic rs_byte_t gf_mul(input rs_byte_t a, input rs_byte_t b);
		rs_byte_t prod;
		rs_byte_t sh;
		prod = '0;
		sh = a;
		for (int i = 0; i < 8; i++)
		begin
			if (b[i])
				prod ^= sh;
			sh = {sh[6:0], 1'b0} ^ (sh[7] ? GF_POLY[7:0] : 8'h00);   // times x, mod p(x)
		end
		return prod;
	endfunction

endpackage

`default_nettype wire

/* hdl/input_syndromes.sv */
// input stage that registers each byte on ce and tracks its place in the 204-byte block
// it accumulates the sixteen syndromes by Horner's rule
// status pulses with the last beat of a block and reports any nonzero syndrome
`timescale 1ns/1ps
`default_nettype none

`include "rs_params.svh"

module input_syndromes
	import rs_pkg::*;
(
	input  wire         clk,
	input  wire         reset,        // async, active high
	input  wire         ce,           // one clock per input byte
	input  wire rs_byte_t input_byte,
	output in_beat_t    beat,         // byte one clock after ce
	output blk_status_t status        // end of block report
);

	rs_addr_t pos;                      // position of the next byte
	rs_byte_t syn      [`RS_PARITY];    // syndrome registers
	rs_byte_t syn_next [`RS_PARITY];
	logic     first;                    // byte 0 of a block
	logic     last;                     // byte RS_N-1 of a block
	logic     any_err;

	assign first = (pos == '0);
	assign last  = (pos == `RS_N-1);

	// S_i <= S_i * alpha^i + r and a fresh start at the first byte
	always_comb
	begin
		rs_byte_t apow;
		apow = 8'h01;               // alpha^0
		any_err = 1'b0;
		for (int i = 0; i < `RS_PARITY; i++)
		begin
			syn_next[i] = (first ? 8'h00 : gf_mul(syn[i], apow)) ^ input_byte;
			any_err = any_err | (|syn_next[i]);
			apow = gf_mul(apow, 8'h02);   // next power of alpha
		end
	end

	//////////////////////////////
	// control
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			pos <= '0;
			beat <= '0;
			status <= '0;
		end
		else
		begin
			beat.ce <= ce;
			status.ready <= ce && last;     // same clock as the beat with index RS_N-1
			if (ce)
			begin
				beat.data <= input_byte;
				beat.index <= pos;
				pos <= last ? '0 : pos + 1'b1;   // wrap at RS_N
				if (last)
					status.error <= any_err;       // includes the final byte
			end
		end
	end

	//////////////////////////////
	// syndromes
	always_ff @(posedge clk)
	begin
		if (ce)
			for (int i = 0; i < `RS_PARITY; i++)
				syn[i] <= syn_next[i];
	end

	// bytes must leave room for the output pacing downstream
	a_ce_spacing: assert property (@(posedge clk) disable iff (reset)
		ce |=> !ce [*(`RS_OUT_SPACING-1)]);

endmodule

`default_nettype wire

/* hdl/dp_ram.sv */
// one bank of block storage, RS_K bytes deep
// write port and registered read port are independent
`timescale 1ns/1ps
`default_nettype none

`include "rs_params.svh"

module dp_ram
(
	input  wire                  clk,
	input  wire                  we,
	input  wire [`RS_ADDR_W-1:0] wr_addr,
	input  wire [7:0]            wr_data,
	input  wire                  re,
	input  wire [`RS_ADDR_W-1:0] rd_addr,
	output logic [7:0]           rd_data   // valid the clock after re
);

	logic [7:0] mem [0:`RS_K-1];

	always_ff @(posedge clk)
	begin
		if (we)
			mem[wr_addr] <= wr_data;
		if (re)
			rd_data <= mem[rd_addr];   // holds between reads
	end

endmodule

`default_nettype wire

/* hdl/block_buffer.sv */
// ping-pong block store between the input and output stages
// data bytes go to the write bank, reads come from the other one,
// and the banks swap when a block ends
`timescale 1ns/1ps
`default_nettype none

`include "rs_params.svh"

module block_buffer
	import rs_pkg::*;
(
	input  wire         clk,
	input  wire         reset,
	input  wire in_beat_t    beat,     // from input stage
	input  wire blk_status_t status,   // end of block from input stage
	input  wire rd_req_t     rd,       // read request from output stage
	output rs_byte_t    rd_data,       // one clock after rd.en
	output blk_status_t done           // block ready to stream
);

	logic     wr_bank;    // 0: bank0 takes writes
	logic     rd_sel;     // bank that answered the last read
	logic     wr_ok;
	logic     we0, we1;
	logic     re0, re1;
	rs_byte_t q0, q1;

	assign wr_ok = beat.ce && (beat.index < `RS_K);   // parity bytes are not kept
	assign we0 = wr_ok && !wr_bank;
	assign we1 = wr_ok && wr_bank;
	assign re0 = rd.en && wr_bank;    // read side is the idle bank
	assign re1 = rd.en && !wr_bank;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wr_bank <= 1'b0;
			rd_sel <= 1'b0;
			done <= '0;
		end
		else
		begin
			done.ready <= status.ready;    // one clock behind, as the bank flips
			if (status.ready)
			begin
				wr_bank <= !wr_bank;
				done.error <= status.error;
			end
			if (rd.en)
				rd_sel <= !wr_bank;     // follows the registered read data
		end
	end

	assign rd_data = rd_sel ? q1 : q0;

	//////////////////////////////
	// banks
	dp_ram bank0
	(
		.clk     (clk),
		.we      (we0),
		.wr_addr (beat.index),
		.wr_data (beat.data),
		.re      (re0),
		.rd_addr (rd.addr),
		.rd_data (q0)
	);

	dp_ram bank1
	(
		.clk     (clk),
		.we      (we1),
		.wr_addr (beat.index),
		.wr_data (beat.data),
		.re      (re1),
		.rd_addr (rd.addr),
		.rd_data (q1)
	);

	// block end must line up with the last position, so data writes stay below RS_K
	a_frame: assert property (@(posedge clk) disable iff (reset)
		beat.ce |-> ((beat.index == `RS_N-1) == status.ready));

	// output stage addresses stay inside a bank
	a_rd_range: assert property (@(posedge clk) disable iff (reset)
		rd.en |-> (rd.addr < `RS_K));

endmodule

`default_nettype wire

/* hdl/out_stage.sv */
// output stage: streams a finished bank, one byte every RS_OUT_SPACING clocks
// each slot issues a read, then shows the returned byte with a ceo pulse
// block_error is held from the first ceo of a block until the next done
`timescale 1ns/1ps
`default_nettype none

`include "rs_params.svh"

module out_stage
	import rs_pkg::*;
(
	input  wire         clk,
	input  wire         reset,
	input  wire blk_status_t done,     // block finished, bank flipped
	output rd_req_t     rd,            // read of the finished bank
	input  wire rs_byte_t    rd_data,  // returns the clock after rd.en
	output rs_byte_t    out_byte,
	output logic        ceo,           // one clock per output byte
	output logic        valid_out,     // high across a block's output
	output logic        block_error    // block had a nonzero syndrome
);

	logic                               busy;       // streaming a bank
	logic [$clog2(`RS_OUT_SPACING)-1:0] slot_cnt;   // clocks within a slot
	rs_addr_t                           addr;       // address of latest read
	logic                               slot_end;
	logic                               issue;
	logic                               rd_pend;    // read data arrives now
	logic                               last_q;     // final ceo went out
	logic                               err_q;      // error of the block in hand

	assign slot_end = busy && (slot_cnt == `RS_OUT_SPACING-1);
	assign issue = done.ready || (slot_end && (addr != `RS_K-1));
	assign rd.en = issue;
	assign rd.addr = done.ready ? '0 : addr + 1'b1;   // first read is address 0

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			slot_cnt <= '0;
			addr <= '0;
			rd_pend <= 1'b0;
			last_q <= 1'b0;
			err_q <= 1'b0;
			ceo <= 1'b0;
			valid_out <= 1'b0;
			block_error <= 1'b0;
		end
		else
		begin
			rd_pend <= issue;
			ceo <= rd_pend;                             // byte registered alongside
			last_q <= rd_pend && (addr == `RS_K-1);
			if (done.ready)
			begin
				busy <= 1'b1;
				slot_cnt <= '0;
				addr <= '0;
				err_q <= done.error;
				block_error <= 1'b0;                    // cleared until first ceo
			end
			else if (busy)
			begin
				slot_cnt <= slot_end ? '0 : slot_cnt + 1'b1;
				if (slot_end)
				begin
					if (addr == `RS_K-1)
						busy <= 1'b0;                     // bank drained
					else
						addr <= addr + 1'b1;
				end
			end
			if (rd_pend)
				valid_out <= 1'b1;
			else if (last_q)
				valid_out <= 1'b0;                      // drop after the last ceo
			if (rd_pend && (addr == '0))
				block_error <= err_q;                   // shows with the first ceo
		end
	end

	// output byte
	always_ff @(posedge clk)
	begin
		if (rd_pend)
			out_byte <= rd_data;
	end

	// a new block must not finish while the previous bank is still streaming
	a_no_overrun: assert property (@(posedge clk) disable iff (reset)
		done.ready |-> !busy);

endmodule

`default_nettype wire

/* hdl/rs_detect_top.sv */
// RS(204,188) error detector top level
// bytes in on ce, data bytes out every RS_OUT_SPACING clocks with ceo,
// block_error flags any block whose syndromes are not all zero
`timescale 1ns/1ps
`default_nettype none

module rs_detect_top
	import rs_pkg::*;
(
	input  wire       clk,
	input  wire       reset,        // async, active high
	input  wire       ce,           // one clock per input byte
	input  wire rs_byte_t input_byte,
	output rs_byte_t  out_byte,
	output logic      ceo,
	output logic      valid_out,
	output logic      block_error
);

	in_beat_t    beat;      // registered input byte
	blk_status_t status;    // syndromes done
	blk_status_t done;      // bank ready to stream
	rd_req_t     rd;
	rs_byte_t    rd_data;

	input_syndromes u_input_syndromes
	(
		.clk        (clk),
		.reset      (reset),
		.ce         (ce),
		.input_byte (input_byte),
		.beat       (beat),
		.status     (status)
	);

	block_buffer u_block_buffer
	(
		.clk     (clk),
		.reset   (reset),
		.beat    (beat),
		.status  (status),
		.rd      (rd),
		.rd_data (rd_data),
		.done    (done)
	);

	out_stage u_out_stage
	(
		.clk         (clk),
		.reset       (reset),
		.done        (done),
		.rd          (rd),
		.rd_data     (rd_data),
		.out_byte    (out_byte),
		.ceo         (ceo),
		.valid_out   (valid_out),
		.block_error (block_error)
	);

endmodule

`default_nettype wire

/* test/tb_rs_model.svh */
// testbench reference model for RS(204,188) over GF(256)
// holds log tables, the generator g(x) = (x+1)(x+a)..(x+a^15) and a systematic encoder
// included inside the testbench module; call build_field, then build_generator
`ifndef TB_RS_MODEL_SVH
`define TB_RS_MODEL_SVH

	rs_byte_t alog [0:254];          // alpha^i
	int       glog [0:255];          // log of a nonzero byte
	rs_byte_t gen  [0:`RS_PARITY];   // g(x), gen[k] is the x^k coefficient
	rs_byte_t cw   [0:`RS_N-1];      // codeword, cw[0] goes out first

	function automatic void build_field();
		logic [8:0] v;
		v = 9'h001;
		for (int i = 0; i < 255; i++)
		begin
			alog[i] = v[7:0];
			glog[v[7:0]] = i;
			v = v << 1;
			if (v[8])
				v = v ^ `RS_GF_POLY;   // reduce back into the field
		end
	endfunction

	// table multiply, zero has no log
	function automatic rs_byte_t field_mul(input rs_byte_t a, input rs_byte_t b);
		if (a == 8'h00 || b == 8'h00)
			return 8'h00;
		return alog[(glog[a] + glog[b]) % 255];
	endfunction

	function automatic void build_generator();
		for (int k = 0; k <= `RS_PARITY; k++)
			gen[k] = 8'h00;
		gen[0] = 8'h01;
		for (int i = 0; i < `RS_PARITY; i++)
		begin
			// times (x + alpha^i), top coefficient first
			for (int k = i + 1; k > 0; k--)
				gen[k] = gen[k-1] ^ field_mul(gen[k], alog[i]);
			gen[0] = field_mul(gen[0], alog[i]);
		end
	endfunction

	// parity = d(x)*x^16 mod g(x), by the usual division LFSR
	function automatic void encode_block();
		rs_byte_t par [`RS_PARITY];
		rs_byte_t fb;
		for (int k = 0; k < `RS_PARITY; k++)
			par[k] = 8'h00;
		for (int i = 0; i < `RS_K; i++)
		begin
			fb = cw[i] ^ par[`RS_PARITY-1];
			for (int k = `RS_PARITY-1; k > 0; k--)
				par[k] = par[k-1] ^ field_mul(fb, gen[k]);
			par[0] = field_mul(fb, gen[0]);
		end
		for (int j = 0; j < `RS_PARITY; j++)
			cw[`RS_K + j] = par[`RS_PARITY-1-j];   // highest degree first
	endfunction

`endif

/* test/tb_rs_detect.sv */
// testbench for the RS(204,188) error detector
// reads block cases from test/rs_cases.txt, encodes random data with the model,
// injects the listed byte errors and checks every streamed byte, the ceo spacing,
// valid_out and block_error; a case can also cut a block short with a reset
`timescale 1ns/1ps
`default_nettype none

`include "rs_params.svh"

module tb_rs_detect
	import rs_pkg::*;
();

	localparam int WAIT_LIMIT = 6000;   // clocks allowed for any wait on the DUT
	localparam int MAX_CASES  = 16;
	localparam int ERR_STRIDE = 17;     // distance between injected errors

	logic     clk;
	logic     reset;
	logic     ce;
	rs_byte_t input_byte;
	rs_byte_t out_byte;
	logic     ceo;
	logic     valid_out;
	logic     block_error;

	logic [31:0] cases [0:MAX_CASES-1];   // {gap, err count, first pos, err xor}
	integer      seed;
	rs_byte_t    exp_data [$];            // data bytes still to come out
	logic        exp_err [$];             // block_error per queued block
	int          blocks_queued;
	int          blocks_checked;
	int          n_cases;
	int          n_blocks;

	`include "tb_rs_model.svh"

	rs_detect_top DUT
	(
		.clk         (clk),
		.reset       (reset),
		.ce          (ce),
		.input_byte  (input_byte),
		.out_byte    (out_byte),
		.ceo         (ceo),
		.valid_out   (valid_out),
		.block_error (block_error)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#50 clk = ~clk;   // 100 ns period
	end

	//////////////////////////////
	// checks
	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic check_byte(input string name, input rs_byte_t got, input rs_byte_t exp);
		if (got !== exp)
			fail_now($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			fail_now($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	//////////////////////////////
	// stimulus
	task automatic step_clock();
		@(posedge clk);
		#10;   // inputs change just after the edge
	endtask

	// 4 clocks of reset, outputs must stay quiet throughout
	task automatic apply_reset();
		reset = 1'b1;
		ce = 1'b0;
		for (int i = 0; i < 4; i++)
		begin
			@(negedge clk);
			check_flag("ceo", ceo, 1'b0);
			check_flag("valid_out", valid_out, 1'b0);
			step_clock();
		end
		reset = 1'b0;
	endtask

	task automatic make_block(input logic [7:0] cnt, input logic [7:0] pos, input rs_byte_t ev);
		for (int i = 0; i < `RS_K; i++)
			cw[i] = rs_byte_t'($random(seed));
		encode_block();
		if (cnt != 8'hff)
			for (int e = 0; e < cnt; e++)
				cw[pos + ERR_STRIDE*e] ^= ev;   // received, not corrected
	endtask

	task automatic send_block(input int gap, input int nbytes);
		for (int i = 0; i < nbytes; i++)
		begin
			ce = 1'b1;
			input_byte = cw[i];
			step_clock();
			ce = 1'b0;
			repeat (gap - 1)
				step_clock();
		end
	endtask

	// all queued blocks out before a mid-block reset
	task automatic wait_drained();
		int waited;
		waited = 0;
		while (blocks_checked != blocks_queued)
		begin
			step_clock();
			waited++;
			if (waited > WAIT_LIMIT)
				fail_now("timeout: output never drained before the mid-block reset");
		end
	endtask

	task automatic drive_cases();
		logic [7:0] gap;
		logic [7:0] cnt;
		logic [7:0] pos;
		logic [7:0] ev;
		for (int c = 0; c < n_cases; c++)
		begin
			{gap, cnt, pos, ev} = cases[c];
			make_block(cnt, pos, ev);
			if (cnt == 8'hff)
			begin
				wait_drained();
				send_block(gap, pos);   // partial block, then thrown away
				apply_reset();
			end
			else
			begin
				for (int j = 0; j < `RS_K; j++)
					exp_data.push_back(cw[j]);
				exp_err.push_back(cnt != 8'h00);
				blocks_queued++;
				send_block(gap, `RS_N);
			end
		end
	endtask

	//////////////////////////////
	// output monitor, samples on the falling edge
	task automatic watch_output(input int nblocks);
		logic exp_e;
		int   waited;
		for (int b = 0; b < nblocks; b++)
		begin
			waited = 0;
			@(negedge clk);
			while (!ceo)
			begin
				check_flag("valid_out", valid_out, 1'b0);   // idle between blocks
				waited++;
				if (waited > WAIT_LIMIT)
					fail_now($sformatf("timeout waiting for the first ceo of block %0d", b));
				@(negedge clk);
			end
			exp_e = exp_err.pop_front();
			for (int j = 0; j < `RS_K; j++)
			begin
				if (j > 0)
				begin
					for (int k = 1; k < `RS_OUT_SPACING; k++)
					begin
						@(negedge clk);
						if (ceo)
							fail_now($sformatf("ceo came early for byte %0d of block %0d", j, b));
					end
					@(negedge clk);
					if (!ceo)
						fail_now($sformatf("ceo missing for byte %0d of block %0d", j, b));
				end
				check_byte($sformatf("out_byte[%0d]", j), out_byte, exp_data.pop_front());
				check_flag("valid_out", valid_out, 1'b1);
				check_flag("block_error", block_error, exp_e);
			end
			@(negedge clk);
			check_flag("valid_out", valid_out, 1'b0);   // drops after the last ceo
			blocks_checked++;
		end
	endtask

	initial
	begin
		seed = 32'hc371_37f2;
		reset = 1'b1;
		ce = 1'b0;
		input_byte = 8'h00;
		blocks_queued = 0;
		blocks_checked = 0;
		for (int i = 0; i < MAX_CASES; i++)
			cases[i] = 32'h0;
		$readmemh("test/rs_cases.txt", cases);
		n_cases = 0;
		n_blocks = 0;
		while (n_cases < MAX_CASES && cases[n_cases][31:24] != 8'h00)
		begin
			if (cases[n_cases][23:16] != 8'hff)
				n_blocks++;
			n_cases++;
		end
		if (n_blocks == 0)
			fail_now("no usable cases in test/rs_cases.txt");
		build_field();
		build_generator();
		apply_reset();
		fork
			drive_cases();
			watch_output(n_blocks);
		join
		for (int i = 0; i < 2*`RS_OUT_SPACING; i++)
		begin
			@(negedge clk);
			if (ceo)
				fail_now("ceo pulsed after the last expected byte");
		end
		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

/* test/rs_cases.txt */
// columns, hex: gap_errcount_firstpos_errxor, errors sit 17 bytes apart
// errcount ff sends firstpos bytes of a block, then resets mid-block
08_00_00_00
08_01_05_3c
0a_00_00_00
08_01_c5_ff
08_03_10_a5
08_02_a0_01
08_01_bc_7e
08_ff_64_00
08_00_00_00
0c_01_cb_42

/* verilog.f */
+incdir+hdl
+incdir+test
hdl/rs_pkg.sv
hdl/input_syndromes.sv
hdl/dp_ram.sv
hdl/block_buffer.sv
hdl/out_stage.sv
hdl/rs_detect_top.sv
test/tb_rs_detect.sv

/* Bender.yml */
package:
  name: rs_detect

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rs_pkg.sv
      - hdl/input_syndromes.sv
      - hdl/dp_ram.sv
      - hdl/block_buffer.sv
      - hdl/out_stage.sv
      - hdl/rs_detect_top.sv
  - target: test
    include_dirs:
      - hdl
      - test
    files:
      - test/tb_rs_detect.sv
